/* sources.f */
mips_pkg.sv
mem_decode.sv
mem_stage.sv
data_ram.sv
wb_stage.sv
mem_subsys.sv
mem_subsys_chk.sv
tb_mem_subsys.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0 --timescale 1ns/1ps
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
TOP        := tb_mem_subsys
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mips_pkg::*; ();

    localparam funct_t FN_ADDU = 6'h21;
    localparam int N_REG = 48;
    localparam int N_SUB = 120;
    localparam int N_MIS = 16;
    localparam int N_MIX = 1500;
    // Issued instructions plus a margin for reset and drain
    localparam int MAX_CYCLES = N_REG + 2 * RAM_WORDS + 5 * N_SUB + 2 * N_MIS + N_MIX + 21;

    typedef struct packed {
        int unsigned cyc;
        reg_adr_t    adr;
        word_t       data;
        logic        fault;
    } exp_t;

    logic        clk = 1'b0;
    logic        rst_n;
    word_t       instr;
    word_t       pc;
    word_t       alu_res;
    word_t       mlu_res;
    word_t       reg_rt;
    word_t       imm32;
    reg_adr_t    regw_adr;
    word_t       reg_write;
    logic        mem_fault;
    word_t       shadow [RAM_WORDS];                  // Expected RAM contents
    word_t       rng = 32'd65;
    int unsigned cyc = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    string       test_name = "reset";
    exp_t        exp_q [$];
    string       name_q [$];
    opcode_t     mis_ops [4] = '{OP_LW, OP_LH, OP_SW, OP_SH};
    funct_t      r_fns [4] = '{FN_ADDU, FN_MFHI, FN_MFLO, FN_JR};
    opcode_t     mix_ops [12] = '{OP_SPECIAL, OP_SPECIAL, OP_LUI, OP_JAL, OP_LW, OP_LH,
                                  OP_LHU, OP_LB, OP_LBU, OP_SW, OP_SH, OP_SB};

    mem_subsys UUT (.*);

    bind mem_subsys mem_subsys_chk u_chk (.clk(clk), .rst_n(rst_n), .instr(instr),
        .ram_we(ram_we), .ram_be(ram_be), .regw_adr(regw_adr), .mem_fault(mem_fault));

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout at cycle %0d with %0d results still pending", cyc, exp_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic word_t rand_word();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic reg_adr_t rand_reg();          // Never register 0
        return 5'(rand_word() % 31 + 1);
    endfunction

    function automatic word_t enc(opcode_t op, reg_adr_t rt, reg_adr_t rd, funct_t fn);
        return {op, 5'd9, rt, rd, 5'd0, fn};
    endfunction

    function automatic exp_t ref_result(word_t ins, word_t a, word_t m, word_t im, word_t p);
        exp_t        e;
        logic        wen;
        logic [15:0] h;
        logic [7:0]  b;
        opcode_t     op;
        op    = ins[31:26];
        h     = a[1] ? shadow[a[9:2]][31:16] : shadow[a[9:2]][15:0];
        b     = shadow[a[9:2]][8 * a[1:0] +: 8];
        e     = '0;
        e.adr = ins[20:16];                           // rt unless replaced below
        wen   = 1'b1;
        case (op)
            OP_SPECIAL: begin
                e.adr  = ins[15:11];
                wen    = (ins[5:0] != FN_JR);
                e.data = (ins[5:0] == FN_MFHI || ins[5:0] == FN_MFLO) ? m : a;
            end
            OP_LUI: e.data = im;
            OP_JAL: begin
                e.adr  = 5'd31;
                e.data = p + 32'd8;
            end
            OP_LW: begin
                e.fault = (a[1:0] != 2'b00);
                e.data  = shadow[a[9:2]];
            end
            OP_LH, OP_LHU: begin
                e.fault = a[0];
                e.data  = {{16{op == OP_LH && h[15]}}, h};
            end
            OP_LB, OP_LBU: e.data = {{24{op == OP_LB && b[7]}}, b};
            OP_SW, OP_SH, OP_SB: begin
                wen     = 1'b0;
                e.fault = (op == OP_SW && a[1:0] != 2'b00) || (op == OP_SH && a[0]);
            end
            default: wen = 1'b0;
        endcase
        if (e.fault || !wen || e.adr == 5'd0) begin
            e.adr  = '0;
            e.data = '0;
        end
        return e;
    endfunction

    task automatic issue(word_t ins, word_t a, word_t rt);
        exp_t e;
        @(posedge clk);
        #1;
        instr   = ins;
        alu_res = a;
        reg_rt  = rt;
        mlu_res = rand_word();
        imm32   = rand_word();
        pc      = rand_word();
        e       = ref_result(ins, a, mlu_res, imm32, pc);
        e.cyc   = cyc;
        exp_q.push_back(e);
        name_q.push_back(test_name);
        if (ins[31:26] == OP_SW && a[1:0] == 2'b00) begin
            shadow[a[9:2]] = rt;
        end else if (ins[31:26] == OP_SH && !a[0]) begin
            shadow[a[9:2]][16 * a[1] +: 16] = rt[15:0];
        end else if (ins[31:26] == OP_SB) begin
            shadow[a[9:2]][8 * a[1:0] +: 8] = rt[7:0];
        end
    endtask

    task automatic check_adr(string name, reg_adr_t exp, reg_adr_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s regw_adr: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s reg_write: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s mem_fault: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Result of the instruction from the previous cycle
    always @(negedge clk) begin
        if (exp_q.size() != 0 && exp_q[0].cyc == cyc - 1) begin
            check_adr(name_q[0], exp_q[0].adr, regw_adr);
            check_word(name_q[0], exp_q[0].data, reg_write);
            check_bit(name_q[0], exp_q[0].fault, mem_fault);
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
        end
    end

    initial begin
        word_t a;
        {instr, pc, alu_res, mlu_res, reg_rt, imm32} = '0;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_adr("reset", '0, regw_adr);
        check_word("reset", '0, reg_write);
        check_bit("reset", 1'b0, mem_fault);

        test_name = "reg_write";
        for (int i = 0; i < N_REG; i++) begin
            if (i % 6 == 4) begin
                issue(enc(OP_LUI, i[4:0], rand_reg(), FN_ADDU), rand_word(), rand_word());
            end else if (i % 6 == 5) begin
                issue(enc(OP_JAL, rand_reg(), rand_reg(), FN_ADDU), rand_word(), rand_word());
            end else begin
                issue(enc(OP_SPECIAL, rand_reg(), i[4:0], r_fns[i % 6]), rand_word(), rand_word());
            end
        end

        test_name = "fill";
        for (int i = 0; i < RAM_WORDS; i++) begin
            a = {22'd0, i[7:0], 2'b00};
            issue(enc(OP_SW, rand_reg(), 5'd0, 6'd0), a, rand_word());
            issue(enc(OP_LW, rand_reg(), 5'd0, 6'd0), a, rand_word());
        end

        test_name = "sub_word";
        for (int i = 0; i < N_SUB; i++) begin
            a = {22'd0, 8'(rand_word()), 2'(rand_word())};
            a[0] = a[0] && i[0];                      // sh stays halfword aligned
            issue(enc(i[0] ? OP_SB : OP_SH, rand_reg(), 5'd0, 6'd0), a, rand_word());
            a[1:0] = 2'(rand_word() & 32'd2);
            issue(enc(OP_LH, rand_reg(), 5'd0, 6'd0), a, rand_word());
            issue(enc(OP_LHU, rand_reg(), 5'd0, 6'd0), a, rand_word());
            a[1:0] = 2'(rand_word());
            issue(enc(OP_LB, rand_reg(), 5'd0, 6'd0), a, rand_word());
            issue(enc(OP_LBU, rand_reg(), 5'd0, 6'd0), a, rand_word());
        end

        test_name = "misaligned";
        for (int i = 0; i < N_MIS; i++) begin
            a = {22'd0, 8'(rand_word()), 2'(i / 4 % 3 + 1)};
            a[0] = a[0] | i[0];                       // Odd offset for lh and sh
            issue(enc(mis_ops[i % 4], rand_reg(), 5'd0, 6'd0), a, rand_word());
            a[1:0] = 2'b00;
            issue(enc(OP_LW, rand_reg(), 5'd0, 6'd0), a, rand_word());
        end

        test_name = "random_mix";
        for (int i = 0; i < N_MIX; i++) begin
            a = rand_word();
            if (a[31]) begin
                a[1:0] = 2'b00;
            end
            issue(enc(mix_ops[rand_word() % 12], 5'(rand_word()), 5'(rand_word()),
                      r_fns[rand_word() % 4]), a, rand_word());
        end

        test_name = "drain";
        issue('0, '0, '0);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_subsys_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_chk import mips_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  word_t     instr,
    input  wire       ram_we,
    input  lane_en_t  ram_be,
    input  reg_adr_t  regw_adr,
    input  wire       mem_fault
);

    logic started;                                    // First real instruction seen

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (instr != '0) begin
            started <= 1'b1;
        end
    end

    a_we_has_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        ram_we |-> ram_be != '0)
        else $error("RAM write with no byte lane enabled");

    a_fault_no_target: assert property (@(posedge clk) disable iff (!rst_n)
        mem_fault |-> regw_adr == '0)
        else $error("Faulting access still names a target register");

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> regw_adr == '0)
        else $error("Register address set before any result was due");

endmodule

`default_nettype wire

/* mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys import mips_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  word_t     instr,
    input  word_t     pc,
    input  word_t     alu_res,
    input  word_t     mlu_res,
    input  word_t     reg_rt,
    input  word_t     imm32,
    output reg_adr_t  regw_adr,
    output word_t     reg_write,
    output logic      mem_fault
);

    logic [RAM_AW-1:0] ram_adr;
    word_t             ram_wdata;
    lane_en_t          ram_be;
    logic              ram_we;
    word_t             ram_rdata;

    reg_adr_t    w_dst;
    logic        w_regw_en;
    wb_src_t     w_src;
    width_t      w_width;
    logic        w_sign;
    logic [1:0]  w_lane;
    word_t       w_alu;
    word_t       w_mlu;
    word_t       w_imm;
    word_t       w_link;
    logic        w_fault;

    mem_stage u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .pc        (pc),
        .alu_res   (alu_res),
        .mlu_res   (mlu_res),
        .reg_rt    (reg_rt),
        .imm32     (imm32),
        .ram_adr   (ram_adr),
        .ram_wdata (ram_wdata),
        .ram_be    (ram_be),
        .ram_we    (ram_we),
        .w_dst     (w_dst),
        .w_regw_en (w_regw_en),
        .w_src     (w_src),
        .w_width   (w_width),
        .w_sign    (w_sign),
        .w_lane    (w_lane),
        .w_alu     (w_alu),
        .w_mlu     (w_mlu),
        .w_imm     (w_imm),
        .w_link    (w_link),
        .w_fault   (w_fault)
    );

    data_ram u_ram (
        .clk   (clk),
        .adr   (ram_adr),
        .wdata (ram_wdata),
        .be    (ram_be),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

    wb_stage u_wb (
        .rdata     (ram_rdata),
        .w_dst     (w_dst),
        .w_regw_en (w_regw_en),
        .w_src     (w_src),
        .w_width   (w_width),
        .w_sign    (w_sign),
        .w_lane    (w_lane),
        .w_alu     (w_alu),
        .w_mlu     (w_mlu),
        .w_imm     (w_imm),
        .w_link    (w_link),
        .w_fault   (w_fault),
        .regw_adr  (regw_adr),
        .reg_write (reg_write),
        .mem_fault (mem_fault)
    );

endmodule

`default_nettype wire

/* wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_stage import mips_pkg::*; (
    input  word_t        rdata,
    input  reg_adr_t     w_dst,
    input  wire          w_regw_en,
    input  wb_src_t      w_src,
    input  width_t       w_width,
    input  wire          w_sign,
    input  wire  [1:0]   w_lane,
    input  word_t        w_alu,
    input  word_t        w_mlu,
    input  word_t        w_imm,
    input  word_t        w_link,
    input  wire          w_fault,
    output reg_adr_t     regw_adr,
    output word_t        reg_write,
    output logic         mem_fault
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;
    word_t       load_data;
    word_t       wb_data;
    logic        wr_ok;

    assign byte_val = rdata[8 * w_lane +: 8];
    assign half_val = w_lane[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (w_width)
            WIDTH_HALF: begin
                load_data = {{16{w_sign & half_val[15]}}, half_val};
            end
            WIDTH_BYTE: begin
                load_data = {{24{w_sign & byte_val[7]}}, byte_val};
            end
            default: begin
                load_data = rdata;                    // Whole word
            end
        endcase
    end

    always_comb begin
        case (w_src)
            SRC_MEM:  wb_data = load_data;
            SRC_IMM:  wb_data = w_imm;
            SRC_LINK: wb_data = w_link;
            SRC_MLU:  wb_data = w_mlu;
            default:  wb_data = w_alu;
        endcase
    end

    // Register 0 is never reported as a target
    assign wr_ok     = w_regw_en && (w_dst != 5'd0);
    assign regw_adr  = wr_ok ? w_dst : 5'd0;
    assign reg_write = wr_ok ? wb_data : 32'd0;
    assign mem_fault = w_fault;

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram import mips_pkg::*; (
    input  wire                clk,
    input  wire  [RAM_AW-1:0]  adr,
    input  word_t              wdata,
    input  lane_en_t           be,
    input  wire                we,
    output word_t              rdata
);

    word_t mem [RAM_WORDS];

    // Old contents come out when read and write hit the same word
    always_ff @(posedge clk) begin
        rdata <= mem[adr];
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[adr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage import mips_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  word_t              instr,
    input  word_t              pc,
    input  word_t              alu_res,
    input  word_t              mlu_res,
    input  word_t              reg_rt,
    input  word_t              imm32,
    output logic [RAM_AW-1:0]  ram_adr,
    output word_t              ram_wdata,
    output lane_en_t           ram_be,
    output logic               ram_we,
    output reg_adr_t           w_dst,
    output logic               w_regw_en,
    output wb_src_t            w_src,
    output width_t             w_width,
    output logic               w_sign,
    output logic [1:0]         w_lane,
    output word_t              w_alu,
    output word_t              w_mlu,
    output word_t              w_imm,
    output word_t              w_link,
    output logic               w_fault
);

    logic     mem_we;
    logic     regw_en;
    dst_sel_t dst_sel;
    wb_src_t  wb_src;
    width_t   width;
    logic     sign_ext;
    logic     misaligned;
    lane_en_t lanes;
    reg_adr_t dst;

    mem_decode u_decode (
        .instr    (instr),
        .mem_we   (mem_we),
        .regw_en  (regw_en),
        .dst_sel  (dst_sel),
        .wb_src   (wb_src),
        .width    (width),
        .sign_ext (sign_ext)
    );

    assign misaligned = (width == WIDTH_HALF && alu_res[0]) ||
                        (width == WIDTH_WORD && alu_res[1:0] != 2'b00);

    always_comb begin
        case (width)
            WIDTH_WORD: lanes = 4'b1111;
            WIDTH_HALF: lanes = 4'b0011 << alu_res[1:0];
            WIDTH_BYTE: lanes = 4'b0001 << alu_res[1:0];
            default:    lanes = 4'b0000;
        endcase
    end

    assign ram_adr   = alu_res[RAM_AW+1:2];
    assign ram_wdata = reg_rt << {alu_res[1:0], 3'b000};  // Aligned lanes only
    assign ram_we    = mem_we && !misaligned;
    assign ram_be    = ram_we ? lanes : 4'b0000;

    always_comb begin
        case (dst_sel)
            DST_RD:  dst = instr[RD_LSB +: 5];
            DST_RA:  dst = 5'd31;
            default: dst = instr[RT_LSB +: 5];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_dst     <= '0;
            w_regw_en <= 1'b0;
            w_src     <= SRC_ALU;
            w_width   <= WIDTH_NONE;
            w_sign    <= 1'b0;
            w_lane    <= 2'b00;
            w_fault   <= 1'b0;
        end else begin
            w_dst     <= dst;
            w_regw_en <= regw_en && !misaligned;  // Faulting load writes nothing
            w_src     <= wb_src;
            w_width   <= width;
            w_sign    <= sign_ext;
            w_lane    <= alu_res[1:0];
            w_fault   <= misaligned;
        end
    end

    always_ff @(posedge clk) begin
        w_alu  <= alu_res;
        w_mlu  <= mlu_res;
        w_imm  <= imm32;
        w_link <= pc + 32'd8;
    end

endmodule

`default_nettype wire

/* mem_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_decode import mips_pkg::*; (
    input  word_t    instr,
    output logic     mem_we,
    output logic     regw_en,
    output dst_sel_t dst_sel,
    output wb_src_t  wb_src,
    output width_t   width,
    output logic     sign_ext
);

    opcode_t opcode;
    funct_t  funct;

    assign opcode = instr[OP_LSB +: 6];
    assign funct  = instr[5:0];

    always_comb begin
        // Unknown opcodes fall through to no write at all
        mem_we   = 1'b0;
        regw_en  = 1'b0;
        dst_sel  = DST_RT;
        wb_src   = SRC_ALU;
        width    = WIDTH_NONE;
        sign_ext = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                dst_sel = DST_RD;
                if (funct == FN_MFHI || funct == FN_MFLO) begin
                    regw_en = 1'b1;
                    wb_src  = SRC_MLU;
                end else if (funct != FN_JR) begin
                    regw_en = 1'b1;                   // Plain ALU result
                end
            end
            OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU: begin
                regw_en  = 1'b1;
                wb_src   = SRC_MEM;
                sign_ext = (opcode == OP_LH || opcode == OP_LB);
                if (opcode == OP_LW) begin
                    width = WIDTH_WORD;
                end else if (opcode == OP_LH || opcode == OP_LHU) begin
                    width = WIDTH_HALF;
                end else begin
                    width = WIDTH_BYTE;
                end
            end
            OP_SW: begin
                mem_we = 1'b1;
                width  = WIDTH_WORD;
            end
            OP_SH: begin
                mem_we = 1'b1;
                width  = WIDTH_HALF;
            end
            OP_SB: begin
                mem_we = 1'b1;
                width  = WIDTH_BYTE;
            end
            OP_LUI: begin
                regw_en = 1'b1;
                wb_src  = SRC_IMM;
            end
            OP_JAL: begin
                regw_en = 1'b1;
                dst_sel = DST_RA;
                wb_src  = SRC_LINK;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_adr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  lane_en_t;                   // Bit i covers byte i
    typedef logic [1:0]  width_t;
    typedef logic [2:0]  wb_src_t;
    typedef logic [1:0]  dst_sel_t;

    // Access width
    localparam width_t WIDTH_NONE = 2'd0;
    localparam width_t WIDTH_WORD = 2'd1;
    localparam width_t WIDTH_HALF = 2'd2;
    localparam width_t WIDTH_BYTE = 2'd3;

    // Write-back source
    localparam wb_src_t SRC_ALU  = 3'd0;
    localparam wb_src_t SRC_MEM  = 3'd1;
    localparam wb_src_t SRC_IMM  = 3'd2;
    localparam wb_src_t SRC_LINK = 3'd3;
    localparam wb_src_t SRC_MLU  = 3'd4;

    // Destination register select
    localparam dst_sel_t DST_RT = 2'd0;
    localparam dst_sel_t DST_RD = 2'd1;
    localparam dst_sel_t DST_RA = 2'd2;

    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LB      = 6'h20;
    localparam opcode_t OP_LH      = 6'h21;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_LBU     = 6'h24;
    localparam opcode_t OP_LHU     = 6'h25;
    localparam opcode_t OP_SB      = 6'h28;
    localparam opcode_t OP_SH      = 6'h29;
    localparam opcode_t OP_SW      = 6'h2b;

    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_MFHI = 6'h10;
    localparam funct_t FN_MFLO = 6'h12;

    localparam int RD_LSB = 11;
    localparam int RT_LSB = 16;
    localparam int RS_LSB = 21;
    localparam int OP_LSB = RS_LSB + 5;               // Opcode sits right above rs

    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = 8;

endpackage

`default_nettype wire
